// File: etrig_defines.svh
// ====================
// shared widths and codes for the trigger front end
// select codes must fit the 2-bit select field
// ====================
`ifndef ETRIG_DEFINES_SVH
`define ETRIG_DEFINES_SVH

// period and delay counters, in adc_clk cycles
`define ETRIG_CNT_W 26

// strobe counter, wraps
`define ETRIG_PCNT_W 16

// glitch filter, pulse passes at all ones (127)
`define ETRIG_FILT_W 7

// source select codes
`define ETRIG_SEL_EXT0 2'd0  // pin 0
`define ETRIG_SEL_EXT1 2'd1  // pin 1
`define ETRIG_SEL_EXT2 2'd2  // pin 2
`define ETRIG_SEL_PROG 2'd3  // internal periodic trigger

`endif // ETRIG_DEFINES_SVH

// File: etrig_pkg.sv
// ====================
// types for the trigger front end
// widths come from etrig_defines.svh
// ====================
`include "etrig_defines.svh"

package etrig_pkg;

  // period or delay, in adc_clk cycles
  typedef logic [`ETRIG_CNT_W-1:0] tick_cnt_t;

  // number of strobes issued, wraps
  typedef logic [`ETRIG_PCNT_W-1:0] pulse_cnt_t;

  typedef logic [1:0] trig_sel_t;  // source select code

  typedef logic [`ETRIG_FILT_W-1:0] filt_cnt_t;  // glitch filter counter

  // control fields, 54 bits, quasi-static
  typedef struct packed {
    trig_sel_t sel;     // source select
    tick_cnt_t period;  // periodic trigger spacing minus one
    tick_cnt_t delay;   // delayed strobe offset
  } etrig_ctrl_t;

  // delay machine
  typedef enum logic {
    DLY_IDLE,
    DLY_COUNT
  } dly_state_e;

endpackage

// File: etrig_input_cond.sv
// ====================
// pins are active low and asynchronous to adc_clk
// pulses shorter than 127 cycles after sync are dropped
// ====================
`timescale 1ns/10ps
`include "etrig_defines.svh"

module etrig_input_cond
  import etrig_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  logic [2:0] trign_i,    // active low, async
  input  trig_sel_t sel_i,       // registered select
  output logic      ext_filt_o   // filtered, de-inverted level
);

  logic [2:0] sync_q1;  // first sync stage, one bit per pin
  logic [2:0] sync_q2;  // second stage, safe to use
  logic       sel_trig; // selected pin, active high
  filt_cnt_t  filt_cnt;

  // two-flop synchronizers
  // reset high, pins idle high
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      sync_q1 <= 3'b111;
      sync_q2 <= 3'b111;
    end else begin
      sync_q1 <= trign_i;
      sync_q2 <= sync_q1;  // edge seen here two cycles later
    end
  end

  // invert and pick one pin
  always_comb begin
    case (sel_i)
      `ETRIG_SEL_EXT0: sel_trig = ~sync_q2[0];
      `ETRIG_SEL_EXT1: sel_trig = ~sync_q2[1];
      `ETRIG_SEL_EXT2: sel_trig = ~sync_q2[2];
      `ETRIG_SEL_PROG: sel_trig = 1'b0;  // internal source, pins ignored
      default:         sel_trig = 1'b0;
    endcase
  end

  // saturating glitch filter
  // any low cycle clears it, counts up while high, holds at all ones
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      filt_cnt <= '0;
    end else if (!sel_trig) begin
      filt_cnt <= '0;               // glitch or idle
    end else if (!ext_filt_o) begin
      filt_cnt <= filt_cnt + 1'b1;  // still qualifying
    end
  end

  // high once 127 consecutive high cycles were seen
  assign ext_filt_o = &filt_cnt;

  // falls 3 cycles after the pin returns high
  // (2 sync + 1 clear)

endmodule

// File: etrig_period_gen.sv
// ====================
// pulses spaced period+1 cycles apart, none for period 0
// a new period is taken at the next reload
// ====================
`timescale 1ns/10ps

module etrig_period_gen
  import etrig_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  tick_cnt_t period_i,  // reload value
  output logic      pulse_o    // one cycle, periodic trigger
);

  tick_cnt_t p_cnt;  // down-counter

  // reload on zero, otherwise count down
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      p_cnt <= '0;
    end else if (p_cnt == '0) begin
      p_cnt <= period_i;       // sample period only here
    end else begin
      p_cnt <= p_cnt - 1'b1;
    end
  end

  // flag the count of one
  assign pulse_o = (p_cnt == tick_cnt_t'(1));  // once per reload cycle

endmodule

// File: etrig_delay_line.sv
// ====================
// strobe out 4 cycles after the trigger level rises
// delayed strobe follows by delay_i cycles, retrigger restarts it
// ====================
`timescale 1ns/10ps

module etrig_delay_line
  import etrig_pkg::*;
(
  input  logic       adc_clk,
  input  logic       rst_n_i,
  input  logic       trig_lvl_i,       // selected trigger level
  input  tick_cnt_t  delay_i,          // quasi-static
  output logic       pulse_o,          // one-cycle strobe
  output logic       pulse_delayed_o,  // strobe delayed by delay_i
  output pulse_cnt_t pulse_cnt_o       // strobes issued, wraps
);

  logic       lvl_r;      // level, first stage
  logic       lvl_r1;     // level, second stage
  logic       strobe;     // internal rising-edge strobe
  logic [1:0] pulse_sr;   // aligns pulse_o two cycles after strobe
  pulse_cnt_t pulse_cnt;
  dly_state_e dly_state;
  tick_cnt_t  dly_cnt;    // cycles since strobe
  logic       dly_pulse;  // fsm output, used when delay_i != 0

  // rising edge detect
  // strobe lands two cycles after the level rises
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      lvl_r  <= 1'b0;
      lvl_r1 <= 1'b0;
      strobe <= 1'b0;
    end else begin
      lvl_r  <= trig_lvl_i;
      lvl_r1 <= lvl_r;
      strobe <= lvl_r & ~lvl_r1;  // one cycle per rising edge
    end
  end

  // strobe counter, moves one cycle ahead of pulse_o
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      pulse_cnt <= '0;
    end else if (strobe) begin
      pulse_cnt <= pulse_cnt + 1'b1;  // wraps at 2^16
    end
  end

  // two-stage alignment shift register
  // gives delay 1 exactly one cycle between pulse and delayed pulse
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      pulse_sr <= 2'b00;
    end else begin
      pulse_sr <= {pulse_sr[0], strobe};
    end
  end

  // delay machine
  // counts from the strobe, fires when the count reaches delay_i
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dly_state <= DLY_IDLE;
      dly_cnt   <= '0;
      dly_pulse <= 1'b0;
    end else begin
      dly_pulse <= 1'b0;  // default low, single-cycle pulse
      if (strobe) begin
        // new strobe always restarts, a pending pulse is dropped
        dly_state <= DLY_COUNT;
        dly_cnt   <= '0;
      end else begin
        case (dly_state)
          DLY_IDLE: begin
            dly_cnt <= '0;
          end
          DLY_COUNT: begin
            if (dly_cnt >= delay_i) begin
              dly_pulse <= 1'b1;     // lands delay_i after pulse_o
              dly_state <= DLY_IDLE;
              dly_cnt   <= '0;
            end else begin
              dly_cnt <= dly_cnt + 1'b1;
            end
          end
          default: begin
            dly_state <= DLY_IDLE;
            dly_cnt   <= '0;
          end
        endcase
      end
    end
  end

  assign pulse_o     = pulse_sr[1];
  assign pulse_cnt_o = pulse_cnt;

  // delay 0 means same cycle as pulse_o
  assign pulse_delayed_o = (delay_i == '0) ? pulse_sr[1] : dly_pulse;

endmodule

// File: etrig_bridge.sv
// ====================
// single clock, adc_clk; ctrl_i applies one cycle after it changes
// external path fires 133 cycles after the pin falls
// ====================
`timescale 1ns/10ps
`include "etrig_defines.svh"

module etrig_bridge
  import etrig_pkg::*;
(
  input  logic        adc_clk,
  input  logic        rst_n_i,
  input  logic [2:0]  trign_i,                // active low, async
  input  etrig_ctrl_t ctrl_i,                 // sel, period, delay
  output logic        etrig_pulse_o,          // trigger strobe
  output logic        etrig_pulse_delayed_o,  // delayed strobe
  output pulse_cnt_t  etrig_pulse_cnt_o       // strobe count
);

  etrig_ctrl_t ctrl_r;      // registered control
  logic        prog_pulse;  // internal periodic trigger
  logic        ext_filt;    // filtered external level
  logic        trig_lvl;    // selected source

  // register the control fields once
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      ctrl_r <= '0;
    end else begin
      ctrl_r <= ctrl_i;
    end
  end

  etrig_input_cond u_input_cond (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .trign_i    (trign_i),
    .sel_i      (ctrl_r.sel),
    .ext_filt_o (ext_filt)
  );

  etrig_period_gen u_period_gen (
    .adc_clk  (adc_clk),
    .rst_n_i  (rst_n_i),
    .period_i (ctrl_r.period),
    .pulse_o  (prog_pulse)
  );

  // final source select
  assign trig_lvl = (ctrl_r.sel == `ETRIG_SEL_PROG) ? prog_pulse : ext_filt;

  etrig_delay_line u_delay_line (
    .adc_clk         (adc_clk),
    .rst_n_i         (rst_n_i),
    .trig_lvl_i      (trig_lvl),
    .delay_i         (ctrl_r.delay),
    .pulse_o         (etrig_pulse_o),
    .pulse_delayed_o (etrig_pulse_delayed_o),
    .pulse_cnt_o     (etrig_pulse_cnt_o)
  );

endmodule

// File: etrig_bridge_chk.sv
// ====================
// bound into etrig_bridge, watches strobes and count
// ====================
`timescale 1ns/10ps

module etrig_bridge_chk
  import etrig_pkg::*;
(
  input logic       adc_clk,
  input logic       rst_n_i,
  input logic       trig_lvl_i,       // selected source level
  input tick_cnt_t  delay_i,          // registered delay
  input logic       pulse_i,
  input logic       pulse_delayed_i,
  input pulse_cnt_t pulse_cnt_i
);

  int   fail_cnt = 0;
  logic seen_trig;  // any trigger level since reset

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      seen_trig <= 1'b0;
    end else if (trig_lvl_i) begin
      seen_trig <= 1'b1;
    end
  end

  a_pulse_one: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      pulse_i |=> !pulse_i)
    else begin
      $error("etrig_pulse_o high for two cycles");
      fail_cnt++;
    end

  a_dly_one: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      pulse_delayed_i |=> !pulse_delayed_i)
    else begin
      $error("etrig_pulse_delayed_o high for two cycles");
      fail_cnt++;
    end

  // zero delay, both strobes together
  a_dly_zero: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      (delay_i == '0) |-> (pulse_delayed_i == pulse_i))
    else begin
      $error("delayed strobe differs from strobe with delay 0");
      fail_cnt++;
    end

  a_cnt_then_pulse: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      $changed(pulse_cnt_i) |=> pulse_i)  // count leads by one cycle
    else begin
      $error("count changed without a following strobe");
      fail_cnt++;
    end

  a_quiet_start: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      !seen_trig |-> (!pulse_i && !pulse_delayed_i))
    else begin
      $error("strobe before the first trigger");
      fail_cnt++;
    end

endmodule

bind etrig_bridge etrig_bridge_chk u_chk (
  .adc_clk         (adc_clk),
  .rst_n_i         (rst_n_i),
  .trig_lvl_i      (trig_lvl),
  .delay_i         (ctrl_r.delay),
  .pulse_i         (etrig_pulse_o),
  .pulse_delayed_i (etrig_pulse_delayed_o),
  .pulse_cnt_i     (etrig_pulse_cnt_o)
);

// File: tb_etrig_bridge.sv
// ====================
// directed tests; the external path latency is fixed at 133 cycles
// the run stops at the first mismatch
// ====================
`timescale 1ns/10ps
`include "etrig_defines.svh"

module tb_etrig_bridge
  import etrig_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int EXT_LAT      = 133;  // pin fall to etrig_pulse_o

  // cycle budget of each test
  localparam int RESET_BUDGET  = 400;
  localparam int EXT_BUDGET    = 3200;
  localparam int SEL_BUDGET    = 2000;
  localparam int PROG_BUDGET   = 1500;
  localparam int DLY_BUDGET    = 1600;
  localparam int RETRIG_BUDGET = 800;
  localparam int CYCLE_LIMIT   = RESET_BUDGET + EXT_BUDGET + SEL_BUDGET + PROG_BUDGET
                                 + DLY_BUDGET + RETRIG_BUDGET + 2000;  // plus margin

  logic        adc_clk;
  logic        rst_n;
  logic [2:0]  trign;      // active low pins
  etrig_ctrl_t ctrl;
  logic        pulse;
  logic        pulse_dly;
  pulse_cnt_t  pulse_cnt;

  int cyc = 0;      // rising edges so far
  int pulse_q[$];   // cycle of each etrig_pulse_o
  int cnt_q[$];     // count seen with each pulse
  int dly_q[$];     // cycle of each delayed pulse

  etrig_bridge u_dut (
    .adc_clk               (adc_clk),
    .rst_n_i               (rst_n),
    .trign_i               (trign),
    .ctrl_i                (ctrl),
    .etrig_pulse_o         (pulse),
    .etrig_pulse_delayed_o (pulse_dly),
    .etrig_pulse_cnt_o     (pulse_cnt)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  // cycle count and run limit
  always @(posedge adc_clk) begin
    cyc <= cyc + 1;
    if (cyc > CYCLE_LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $fatal(1, "cycle limit reached");
    end
  end

  // log strobes at the falling edge, outputs are settled there
  always @(negedge adc_clk) begin
    if (rst_n) begin
      if (pulse) begin
        pulse_q.push_back(cyc);
        cnt_q.push_back(int'(pulse_cnt));
      end
      if (pulse_dly) begin
        dly_q.push_back(cyc);
      end
    end
  end

  task automatic check_eq(input int actual, input int expected, input string msg);
    if (actual !== expected) begin
      $display("** Error @ %0t: %s, got %0d, expected %0d", $time, msg, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic set_ctrl(input trig_sel_t sel_v, input tick_cnt_t period_v,
                          input tick_cnt_t delay_v);
    @(posedge adc_clk);
    ctrl <= '{sel: sel_v, period: period_v, delay: delay_v};
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge adc_clk);
  endtask

  task automatic clear_log();
    pulse_q.delete();
    cnt_q.delete();
    dly_q.delete();
  endtask

  task automatic read_count(output int c);
    @(negedge adc_clk);
    c = int'(pulse_cnt);
  endtask

  // low pulse of width cycles, t_fall is the cycle the pin fell
  task automatic pin_pulse(input int pin, input int width, output int t_fall);
    @(posedge adc_clk);
    trign[pin] <= 1'b0;
    @(negedge adc_clk);
    t_fall = cyc;
    repeat (width) @(posedge adc_clk);
    trign[pin] <= 1'b1;
  endtask

  // wait for n logged strobes, gives up after limit cycles
  task automatic wait_events(input bit delayed, input int n, input int limit);
    int waited;
    waited = 0;
    while (waited < limit && (delayed ? dly_q.size() : pulse_q.size()) < n) begin
      @(posedge adc_clk);
      waited++;
    end
  endtask

  task automatic test_reset();
    int c;
    @(negedge adc_clk);
    check_eq(pulse, 0, "etrig_pulse_o after reset");
    check_eq(pulse_dly, 0, "etrig_pulse_delayed_o after reset");
    check_eq(pulse_cnt, 0, "count after reset");
    set_ctrl(`ETRIG_SEL_EXT0, 0, 0);
    clear_log();
    idle(300);  // pins idle high
    read_count(c);
    check_eq(pulse_q.size(), 0, "strobe with pins idle");
    check_eq(dly_q.size(), 0, "delayed strobe with pins idle");
    check_eq(c, 0, "count with pins idle");
  endtask

  task automatic test_ext_pulse();
    int w;
    int tf;
    int c0;
    int c1;
    set_ctrl(`ETRIG_SEL_EXT0, 0, 0);
    idle(3);
    for (int i = 0; i < 3; i++) begin
      w = 131 + ($urandom % 170);  // long enough to pass the filter
      read_count(c0);
      clear_log();
      pin_pulse(0, w, tf);
      wait_events(0, 1, EXT_LAT);
      idle(10);
      check_eq(pulse_q.size(), 1, $sformatf("strobes for a %0d cycle pulse", w));
      check_eq(pulse_q[0], tf + EXT_LAT, "external strobe latency");
      check_eq(cnt_q[0], int'(pulse_cnt_t'(c0 + 1)), "count after external strobe");
    end
    for (int i = 0; i < 3; i++) begin
      w = 1 + ($urandom % 120);  // glitch
      read_count(c0);
      clear_log();
      pin_pulse(0, w, tf);
      idle(EXT_LAT + 10);
      read_count(c1);
      check_eq(pulse_q.size(), 0, $sformatf("strobe for a %0d cycle glitch", w));
      check_eq(c1, c0, "count after glitch");
    end
    for (int pin = 1; pin < 3; pin++) begin
      clear_log();
      pin_pulse(pin, 200, tf);  // unselected pins
      idle(20);
      check_eq(pulse_q.size(), 0, $sformatf("strobe from unselected pin %0d", pin));
    end
  endtask

  task automatic test_select();
    int tf;
    int expect_n;
    for (int code = 0; code < 3; code++) begin
      set_ctrl(trig_sel_t'(code), 0, 0);
      idle(5);
      for (int pin = 0; pin < 3; pin++) begin
        expect_n = (pin == code) ? 1 : 0;
        clear_log();
        pin_pulse(pin, 140, tf);
        idle(10);  // strobe is due before the pin returns
        check_eq(pulse_q.size(), expect_n,
                 $sformatf("select %0d, pulse on pin %0d", code, pin));
        if (expect_n == 1) begin
          check_eq(pulse_q[0], tf + EXT_LAT, "selected pin latency");
        end
      end
    end
  endtask

  task automatic test_prog();
    int period;
    int c0;
    int c1;
    set_ctrl(`ETRIG_SEL_PROG, 0, 0);
    idle(50);
    for (int r = 0; r < 3; r++) begin
      period = 3 + ($urandom % 38);
      read_count(c0);
      clear_log();
      set_ctrl(`ETRIG_SEL_PROG, tick_cnt_t'(period), 0);
      wait_events(0, 6, 7 * (period + 1) + 10);
      check_eq(int'(pulse_q.size() >= 6), 1, $sformatf("six strobes for period %0d", period));
      for (int i = 1; i < 6; i++) begin
        check_eq(pulse_q[i] - pulse_q[i-1], period + 1, "periodic strobe spacing");
      end
      for (int i = 0; i < 6; i++) begin
        check_eq(cnt_q[i], int'(pulse_cnt_t'(c0 + i + 1)), "count per periodic strobe");
      end
      set_ctrl(`ETRIG_SEL_PROG, 0, 0);  // stop, taken at the next reload
      idle(period + 20);
      read_count(c1);
      check_eq(c1, int'(pulse_cnt_t'(c0 + pulse_q.size())), "count against strobes");
    end
    clear_log();
    idle(200);
    check_eq(pulse_q.size(), 0, "strobe with period 0");
  endtask

  task automatic test_delay();
    int d;
    int tf;
    for (int i = 0; i < 6; i++) begin
      d = (i < 2) ? i : 2 + ($urandom % 49);
      set_ctrl(`ETRIG_SEL_EXT2, 0, tick_cnt_t'(d));
      idle(3);
      clear_log();
      pin_pulse(2, 140, tf);
      wait_events(0, 1, 20);
      wait_events(1, 1, d + 20);
      idle(10);
      check_eq(pulse_q.size(), 1, $sformatf("strobes with delay %0d", d));
      check_eq(dly_q.size(), 1, $sformatf("delayed strobes with delay %0d", d));
      check_eq(pulse_q[0], tf + EXT_LAT, "strobe latency in delay test");
      check_eq(dly_q[0] - pulse_q[0], d, "delayed strobe offset");
    end
  endtask

  task automatic test_retrigger();
    int d;
    int tf1;
    int tf2;
    d = 160 + ($urandom % 91);  // longer than the strobe spacing
    set_ctrl(`ETRIG_SEL_EXT0, 0, tick_cnt_t'(d));
    idle(3);
    clear_log();
    pin_pulse(0, 140, tf1);
    idle(4);
    pin_pulse(0, 140, tf2);
    wait_events(0, 2, 30);
    wait_events(1, 1, d + 20);
    idle(20);
    check_eq(pulse_q.size(), 2, "strobes in retrigger test");
    check_eq(pulse_q[1], tf2 + EXT_LAT, "second strobe latency");
    check_eq(dly_q.size(), 1, "delayed strobes after retrigger");
    check_eq(dly_q[0], pulse_q[1] + d, "delayed strobe follows second strobe");
  endtask

  initial begin
    void'($urandom(32'h5112_b796));
    rst_n = 1'b0;
    trign = 3'b111;  // pins idle
    ctrl  = '0;
    repeat (RESET_CYCLES) @(posedge adc_clk);
    rst_n <= 1'b1;
    test_reset();
    test_ext_pulse();
    test_select();
    test_prog();
    test_delay();
    test_retrigger();
    idle(5);
    if (u_dut.u_chk.fail_cnt == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("assertions failed in the checker: %0d", u_dut.u_chk.fail_cnt);
      $display("=== FAIL ===");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// File: compile.f
+incdir+.
etrig_pkg.sv
etrig_input_cond.sv
etrig_period_gen.sv
etrig_delay_line.sv
etrig_bridge.sv
etrig_bridge_chk.sv
tb_etrig_bridge.sv

// File: Bender.yml
package:
  name: etrig_bridge

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - etrig_pkg.sv
      - etrig_input_cond.sv
      - etrig_period_gen.sv
      - etrig_delay_line.sv
      - etrig_bridge.sv
  - target: test
    include_dirs:
      - .
    files:
      - etrig_bridge_chk.sv
      - tb_etrig_bridge.sv
